/* rtl/spi_pin_sync.sv */
// spi pin sync
// oversamples sck, mosi and ss_n on sclk and turns them into
// edge pulses and levels for the rest of the slave
`timescale 1ns/1ps
`default_nettype none

`include "spi_slave_settings.svh"

module spi_pin_sync (
   input  wire                     sclk,
   input  wire                     nreset,
   input  wire                     sck,
   input  wire                     mosi,
   input  wire                     ss_n,
   output spi_slave_pkg::spi_pins_t pins
);

   localparam int S = `SPI_SYNC_STAGES;

   logic [S:0]   sck_q;    // sync chain plus one edge stage
   logic [S:0]   ss_q;     // same for slave select
   logic [S-1:0] mosi_q;   // data needs no edge stage

   //##############################
   // synchronizer chains
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         sck_q  <= '0;            // mode 0 idle level
         ss_q   <= '1;            // deselected, no false edge
         mosi_q <= '0;
      end else begin
         sck_q  <= {sck_q[S-1:0], sck};
         ss_q   <= {ss_q[S-1:0], ss_n};
         mosi_q <= {mosi_q[S-2:0], mosi};
      end
   end

   //##############################
   // edge detect
   //##############################

   // newest synced sample is stage S-1, older one is stage S
   assign pins.sck_rise = sck_q[S-1] & ~sck_q[S];
   assign pins.sck_fall = ~sck_q[S-1] & sck_q[S];
   assign pins.mosi     = mosi_q[S-1];        // lines up with sck edges
   assign pins.selected = ~ss_q[S-1];
   assign pins.deselect = ss_q[S-1] & ~ss_q[S];   // ss_n rising

endmodule

`default_nettype wire

/* rtl/spi_regfile.sv */
// spi register file
// 64 x 8 config/mailbox registers, one sync write port and
// one combinational read port
`timescale 1ns/1ps
`default_nettype none

`include "spi_slave_settings.svh"

module spi_regfile (
   input  wire                    sclk,
   input  wire                    nreset,
   input  spi_slave_pkg::reg_wr_t reg_wr,
   input  wire [`SPI_ADDR_W-1:0]  rd_addr,
   output logic [7:0]             rd_data
);

   logic [7:0] regs [`SPI_REG_COUNT];

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < `SPI_REG_COUNT; i++)
            regs[i] <= 8'h00;              // known config after reset
      end else if (reg_wr.en) begin
         regs[reg_wr.addr] <= reg_wr.data;
      end
   end

   assign rd_data = regs[rd_addr];         // async read for tx load

   // write address stays inside the array
   a_wr_range: assert property (@(posedge sclk) disable iff (!nreset)
      reg_wr.en |-> (int'(reg_wr.addr) < `SPI_REG_COUNT))
      else $error("reg write out of range");

endmodule

`default_nettype wire

/* rtl/spi_rx_shift.sv */
// spi receive shifter
// mosi into a byte history and a wide fetch packet on every enabled
// sck rise, msb or lsb first per lsbfirst
`timescale 1ns/1ps
`default_nettype none

`include "spi_slave_settings.svh"

module spi_rx_shift #(
   parameter int PW = `SPI_PACKET_W       // packet width, 8 or more
) (
   input  wire                      sclk,
   input  wire                      nreset,
   input  spi_slave_pkg::spi_pins_t pins,
   input  wire                      spi_en,
   input  wire                      lsbfirst,
   output logic [7:0]               rx_byte,
   output logic [PW-1:0]            packet_out
);

   logic [6:0]    byte_hist;   // first seven bits of the byte
   logic [PW-1:0] packet;      // last PW bits shifted in
   logic          shift;

   assign shift = pins.sck_rise & spi_en & pins.selected;

   //##############################
   // shift registers
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         byte_hist <= '0;
         packet    <= '0;
      end else if (shift) begin
         if (lsbfirst) begin
            byte_hist <= {pins.mosi, byte_hist[6:1]};   // enters at top
            packet    <= {pins.mosi, packet[PW-1:1]};
         end else begin
            byte_hist <= {byte_hist[5:0], pins.mosi};   // enters at bottom
            packet    <= {packet[PW-2:0], pins.mosi};
         end
      end
   end

   // live bit completes the byte in the same cycle as the 8th rise,
   // tx needs it before the next fall
   assign rx_byte = lsbfirst ? {pins.mosi, byte_hist}
                             : {byte_hist, pins.mosi};

   assign packet_out = packet;

endmodule

`default_nettype wire

/* rtl/spi_slave.sv */
// spi slave top
// mode 0 SPI slave with a 64 x 8 register file and a fetch
// packet handed to the core on deselect, single clock sclk
`timescale 1ns/1ps
`default_nettype none

`include "spi_slave_settings.svh"

module spi_slave (
   input  wire                       sclk,
   input  wire                       nreset,
   input  wire                       sck,
   input  wire                       mosi,
   input  wire                       ss_n,
   output logic                      miso,
   input  wire                       spi_en,
   input  wire                       lsbfirst,
   output logic                      access_out,
   output logic [`SPI_PACKET_W-1:0]  packet_out,
   input  wire                       wait_in
);

   import spi_slave_pkg::*;

   spi_pins_t              pins;
   reg_wr_t                reg_wr;
   logic [`SPI_ADDR_W-1:0] rd_addr;
   logic [7:0]             rd_data;
   logic [7:0]             rx_byte;
   logic                   tx_load;

   spi_pin_sync u_pin_sync (
      .sclk, .nreset, .sck, .mosi, .ss_n, .pins
   );

   spi_slave_ctrl u_ctrl (
      .sclk, .nreset, .pins, .spi_en, .rx_byte, .wait_in,
      .reg_wr, .rd_addr, .tx_load, .access_out
   );

   spi_rx_shift #(.PW(`SPI_PACKET_W)) u_rx_shift (
      .sclk, .nreset, .pins, .spi_en, .lsbfirst, .rx_byte, .packet_out
   );

   spi_tx_shift u_tx_shift (
      .sclk, .nreset, .pins, .spi_en, .lsbfirst, .tx_load, .rd_data, .miso
   );

   spi_regfile u_regfile (
      .sclk, .nreset, .reg_wr, .rd_addr, .rd_data
   );

endmodule

`default_nettype wire

/* rtl/spi_slave_ctrl.sv */
// spi slave control
// transaction FSM for mode 0: command byte first, then data bytes
// drives register writes, tx load strobes and the core fetch pulse
`timescale 1ns/1ps
`default_nettype none

`include "spi_slave_settings.svh"

module spi_slave_ctrl (
   input  wire                       sclk,
   input  wire                       nreset,
   input  spi_slave_pkg::spi_pins_t  pins,
   input  wire                       spi_en,
   input  wire [7:0]                 rx_byte,
   input  wire                       wait_in,
   output spi_slave_pkg::reg_wr_t    reg_wr,
   output logic [`SPI_ADDR_W-1:0]    rd_addr,
   output logic                      tx_load,
   output logic                      access_out
);

   import spi_slave_pkg::*;

   spi_state_t             state;
   logic [2:0]             bit_cnt;     // bit within current byte
   spi_opcode_t            cmd_op;
   logic [`SPI_ADDR_W-1:0] cmd_addr;    // auto-incremented
   logic                   advance;     // enabled sck rise
   logic                   byte_done;   // 8th rise of a byte
   logic                   fetch_hit;   // deselect ends a fetch
   logic                   fetch_pend;  // fetch waiting on wait_in

   assign advance   = pins.sck_rise & spi_en & pins.selected;
   assign byte_done = advance & (bit_cnt == 3'd7) & (state != st_idle);

   //##############################
   // state and bit counter
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         state   <= st_idle;
         bit_cnt <= 3'd0;
      end else if (!pins.selected) begin
         state   <= st_idle;
         bit_cnt <= 3'd0;                 // realign on every select
      end else begin
         if (advance)
            bit_cnt <= bit_cnt + 3'd1;    // wraps at byte end
         case (state)
            st_idle: state <= st_cmd;
            st_cmd:  if (byte_done) state <= st_data;
            st_data: state <= st_data;    // until ss_n rises
            default: state <= st_idle;
         endcase
      end
   end

   //##############################
   // command / address register
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         cmd_op   <= op_nop;
         cmd_addr <= '0;
      end else if (byte_done && state == st_cmd) begin
         cmd_op   <= spi_opcode_t'(rx_byte[7:6]);
         cmd_addr <= rx_byte[`SPI_ADDR_W-1:0];
      end else if (byte_done) begin
         cmd_addr <= cmd_addr + 1'b1;     // mod 64 burst
      end else if (!pins.selected && !pins.deselect) begin
         cmd_op   <= op_nop;              // aborted cmd never fetches
      end
   end

   // regfile ports
   assign rd_addr     = cmd_addr;
   assign reg_wr.en   = byte_done & (state == st_data) & (cmd_op == op_write);
   assign reg_wr.addr = cmd_addr;
   assign reg_wr.data = rx_byte;          // includes bit of this edge

   // first fall of a byte loads next tx byte, none before the cmd byte
   assign tx_load = pins.sck_fall & spi_en & pins.selected & (bit_cnt == 3'd0) &
                    ((state == st_cmd) | (state == st_data));

   //##############################
   // core fetch pulse
   //##############################

   assign fetch_hit = pins.deselect & (cmd_op == op_fetch);

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         fetch_pend <= 1'b0;
         access_out <= 1'b0;
      end else begin
         if (!wait_in)
            fetch_pend <= 1'b0;           // issued this cycle
         else if (fetch_hit)
            fetch_pend <= 1'b1;           // core pushing back
         if (!wait_in)
            access_out <= fetch_hit | fetch_pend;   // held under wait
      end
   end

   // a write strobe only inside a select window
   a_wr_selected: assert property (@(posedge sclk) disable iff (!nreset)
      reg_wr.en |-> pins.selected)
      else $error("reg write while deselected");

   // core pulse traces back to a fetch deselect
   a_access_cause: assert property (@(posedge sclk) disable iff (!nreset)
      $rose(access_out) |-> $past(fetch_hit) || $past(fetch_pend))
      else $error("access_out without deselect");

endmodule

`default_nettype wire

/* rtl/spi_slave_pkg.sv */
// spi slave package
// opcode and state encodings plus the structs passed between the
// pin sync, controller, shifters and register file
`default_nettype none

`include "spi_slave_settings.svh"

package spi_slave_pkg;

   //##############################
   // encodings
   //##############################

   // top two bits of the command byte
   typedef enum logic [1:0] {
      op_write = 2'b00,   // burst write, auto-increment
      op_nop   = 2'b01,   // ignored
      op_read  = 2'b10,   // burst read, auto-increment
      op_fetch = 2'b11    // keep packet, pulse core on deselect
   } spi_opcode_t;

   // controller state
   typedef enum logic [1:0] {
      st_idle = 2'b00,    // ss_n high
      st_cmd  = 2'b01,    // shifting command byte
      st_data = 2'b10     // data bytes until deselect
   } spi_state_t;

   //##############################
   // structs
   //##############################

   // synchronized pin events, all in sclk domain
   typedef struct packed {
      logic sck_rise;     // one-cycle pulse
      logic sck_fall;     // one-cycle pulse
      logic mosi;         // synced data bit
      logic selected;     // level, ss_n low
      logic deselect;     // one-cycle pulse on ss_n rise
   } spi_pins_t;

   // register file write port
   typedef struct packed {
      logic                   en;
      logic [`SPI_ADDR_W-1:0] addr;
      logic [7:0]             data;
   } reg_wr_t;

endpackage

`default_nettype wire

/* rtl/spi_slave_settings.svh */
// spi slave settings
// widths, register count and synchronizer depth for the SPI config/mailbox block
`ifndef SPI_SLAVE_SETTINGS_SVH
`define SPI_SLAVE_SETTINGS_SVH

// register file geometry
`define SPI_ADDR_W      6     // address field of the command byte
`define SPI_REG_COUNT   64    // 2**SPI_ADDR_W registers

// fetch packet kept from the mosi stream
`define SPI_PACKET_W    104   // 13 payload bytes

// pin synchronizer depth
`define SPI_SYNC_STAGES 2

`endif

/* rtl/spi_tx_shift.sv */
// spi transmit shifter
// loads a register byte at each byte start and shifts it out on miso
// on sck falling edges, mode 0
`timescale 1ns/1ps
`default_nettype none

module spi_tx_shift (
   input  wire                      sclk,
   input  wire                      nreset,
   input  spi_slave_pkg::spi_pins_t pins,
   input  wire                      spi_en,
   input  wire                      lsbfirst,
   input  wire                      tx_load,
   input  wire [7:0]                rd_data,
   output logic                     miso
);

   logic [7:0] tx_reg;
   logic       shift;

   assign shift = pins.sck_fall & spi_en;

   //##############################
   // load / shift
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         tx_reg <= '0;
      end else if (!pins.selected) begin
         tx_reg <= '0;                       // idle, nothing to send
      end else if (tx_load) begin
         tx_reg <= rd_data;                  // replaces shift on this fall
      end else if (shift) begin
         if (lsbfirst)
            tx_reg <= {1'b0, tx_reg[7:1]};
         else
            tx_reg <= {tx_reg[6:0], 1'b0};
      end
   end

   // end bit of the register, low while deselected
   assign miso = pins.selected & (lsbfirst ? tx_reg[0] : tx_reg[7]);

   // load comes from the ctrl FSM, must sit on a falling edge
   a_load_on_fall: assert property (@(posedge sclk) disable iff (!nreset)
      tx_load |-> pins.sck_fall)
      else $error("tx_load off sck_fall");

endmodule

`default_nettype wire

/* spi_slave.f */
+incdir+rtl
rtl/spi_slave_pkg.sv
rtl/spi_pin_sync.sv
rtl/spi_slave_ctrl.sv
rtl/spi_rx_shift.sv
rtl/spi_tx_shift.sv
rtl/spi_regfile.sv
rtl/spi_slave.sv
tests/spi_slave_tb.sv

/* tests/spi_slave_tb.sv */
// spi slave testbench
// mode 0 master against the slave, shadow copy of the register file,
// checks read bytes, the fetch packet, access_out and miso idle level
`timescale 1ns/1ps
`default_nettype none

`include "spi_slave_settings.svh"

module spi_slave_tb;

   import spi_slave_pkg::*;

   localparam int HALF_SCK   = 4;     // sclk cycles per sck half period
   localparam int N_TRANS    = 22;    // transactions in the run
   localparam int MAX_BYTES  = 65;    // cmd plus a full 64 byte read
   localparam int MAX_CYCLES = N_TRANS * MAX_BYTES * 8 * 8 + 4000;
   localparam int PW         = `SPI_PACKET_W;

   logic          sclk;
   logic          nreset;
   logic          sck;
   logic          mosi;
   logic          ss_n;
   logic          miso;
   logic          spi_en;
   logic          lsbfirst;
   logic          access_out;
   logic [PW-1:0] packet_out;
   logic          wait_in;

   logic [7:0]    shadow [`SPI_REG_COUNT];   // expected register contents
   logic [7:0]    tx_buf [MAX_BYTES];        // bytes on mosi, cmd first
   logic [7:0]    rx_buf [MAX_BYTES];        // bytes seen on miso
   logic [PW-1:0] exp_packet;
   logic          fetch_expected;            // a core pulse may come
   int            errors;
   int            checks;
   int            cycle_cnt;

   spi_slave dut (
      .sclk, .nreset, .sck, .mosi, .ss_n, .miso, .spi_en, .lsbfirst,
      .access_out, .packet_out, .wait_in
   );

   always #10 sclk = ~sclk;   // 20 ns period

   //##############################
   // reference model
   //##############################

   function automatic logic [7:0] read_ref(input int addr);
      return shadow[addr % `SPI_REG_COUNT];   // burst wraps mod 64
   endfunction

   // last PW bits on the wire, oldest at top for msb first
   function automatic logic [PW-1:0] packet_ref(input logic lsb, input int nbytes);
      logic [PW-1:0] pkt;
      int            a;
      logic          b;
      pkt = '0;
      for (int j = 0; j < nbytes; j++) begin
         for (int k = 0; k < 8; k++) begin
            b = lsb ? tx_buf[j][k] : tx_buf[j][7-k];   // k-th bit sent
            a = j * 8 + k - (nbytes * 8 - PW);           // index in the window
            if (a >= 0) begin
               if (lsb)
                  pkt[a] = b;
               else
                  pkt[PW-1-a] = b;
            end
         end
      end
      return pkt;
   endfunction

   //##############################
   // compare tasks
   //##############################

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
      end
   endtask

   task automatic check_packet(input logic [PW-1:0] got, input logic [PW-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: packet_out 0x%h, expected 0x%h", $time, got, exp);
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   //##############################
   // SPI master
   //##############################

   // one select window, tx_buf out and rx_buf in, ends with ss_n high
   task automatic spi_xfer(input logic lsb, input int nbytes);
      logic [7:0] rx;
      @(negedge sclk);
      lsbfirst = lsb;                         // held for the whole window
      ss_n     = 1'b0;
      repeat (HALF_SCK) @(negedge sclk);
      for (int j = 0; j < nbytes; j++) begin
         rx = 8'h00;
         for (int k = 0; k < 8; k++) begin
            mosi = lsb ? tx_buf[j][k] : tx_buf[j][7-k];   // changes with sck fall
            repeat (HALF_SCK) @(negedge sclk);
            sck = 1'b1;
            rx  = lsb ? {miso, rx[7:1]} : {rx[6:0], miso};
            repeat (HALF_SCK) @(negedge sclk);
            sck = 1'b0;
         end
         rx_buf[j] = rx;
      end
      repeat (HALF_SCK) @(negedge sclk);
      ss_n = 1'b1;
      mosi = 1'b0;
   endtask

   // deselected gap, miso and access_out must stay low
   task automatic settle();
      repeat (HALF_SCK) @(negedge sclk);
      for (int c = 0; c < 4; c++) begin
         @(negedge sclk);
         check_level(miso, 1'b0, "miso while deselected");
         check_level(access_out, 1'b0, "access_out while idle");
      end
   endtask

   task automatic cmd_burst(input spi_opcode_t op, input logic lsb, input int addr, input int n);
      logic [31:0] r;
      tx_buf[0] = {op, addr[`SPI_ADDR_W-1:0]};
      for (int i = 1; i <= n; i++) begin
         r         = $urandom;
         tx_buf[i] = r[7:0];
         if (op == op_write && spi_en)
            shadow[(addr + i - 1) % `SPI_REG_COUNT] = r[7:0];
      end
      spi_xfer(lsb, n + 1);
      settle();
   endtask

   task automatic read_burst(input logic lsb, input int addr, input int n);
      tx_buf[0] = {op_read, addr[`SPI_ADDR_W-1:0]};
      for (int i = 1; i <= n; i++)
         tx_buf[i] = 8'h00;
      spi_xfer(lsb, n + 1);
      for (int i = 1; i <= n; i++)
         check_byte(rx_buf[i], read_ref(addr + i - 1),
                    $sformatf("reg %0d", (addr + i - 1) % `SPI_REG_COUNT));
      settle();
   endtask

   // 13 payload bytes, optional back-pressure across deselect
   task automatic fetch_packet(input logic lsb, input logic hold);
      logic [31:0] r;
      logic        seen;
      for (int i = 0; i < 14; i++) begin
         r         = $urandom;
         tx_buf[i] = r[7:0];
      end
      tx_buf[0][7:6] = op_fetch;
      exp_packet     = packet_ref(lsb, 14);
      fetch_expected = 1'b1;
      wait_in        = hold;
      spi_xfer(lsb, 14);
      if (hold) begin
         repeat (12) begin
            @(negedge sclk);
            check_level(access_out, 1'b0, "access_out under wait_in");
         end
         wait_in = 1'b0;                      // release the core
      end
      seen = 1'b0;
      for (int c = 0; c < 8 && !seen; c++) begin
         @(negedge sclk);
         seen = access_out;
      end
      check_level(seen, 1'b1, "access_out pulse");
      @(negedge sclk);
      check_level(access_out, 1'b0, "access_out one cycle later");
      settle();
   endtask

   //##############################
   // pulse monitor
   //##############################

   always @(negedge sclk) begin
      if (nreset && access_out) begin
         if (!fetch_expected) begin
            errors++;
            $display("[FAIL] %0t ns: access_out high with no fetch pending", $time);
         end else begin
            check_packet(packet_out, exp_packet);
            fetch_expected = 1'b0;            // a second high cycle is an error
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge sclk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d sclk cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
   end

   //##############################
   // stimulus
   //##############################

   initial begin : stimulus
      logic [31:0] r;
      logic        lsb;
      int          start;
      int          len;
      errors = 0;
      checks = 0;
      void'($urandom(32'hba6f_0665));
      sclk = 1'b0;
      nreset = 1'b0;
      sck = 1'b0;
      mosi = 1'b0;
      ss_n = 1'b1;
      spi_en = 1'b1;
      lsbfirst = 1'b0;
      wait_in = 1'b0;
      fetch_expected = 1'b0;
      exp_packet = '0;
      for (int i = 0; i < `SPI_REG_COUNT; i++)
         shadow[i] = 8'h00;
      repeat (3) @(negedge sclk);
      nreset = 1'b1;

      settle();                               // miso idle after reset
      read_burst(1'b0, 0, `SPI_REG_COUNT);    // all zero

      // bursts, first one wraps past 63
      for (int t = 0; t < 6; t++) begin
         r     = $urandom;
         lsb   = (t < 2) ? (t == 1) : r[0];
         start = (t == 0) ? 58 : int'(r[13:8]);
         len   = (t == 0) ? 12 : 1 + int'(r[20:16]);
         cmd_burst(op_write, lsb, start, len);
         read_burst(lsb ^ r[24], start, len);
      end

      // disabled writes and nop leave the registers alone
      r      = $urandom;
      start  = int'(r[5:0]);
      spi_en = 1'b0;
      cmd_burst(op_write, r[8], start, 8);
      spi_en = 1'b1;
      read_burst(r[9], start, 8);
      cmd_burst(op_nop, r[10], start, 8);
      read_burst(r[11], start, 8);

      // fetch in both orders, then a write with no pulse
      fetch_packet(1'b0, 1'b0);
      fetch_packet(1'b1, 1'b0);
      r = $urandom;
      cmd_burst(op_write, r[0], int'(r[13:8]), 4);
      fetch_packet(r[1], 1'b1);               // core holds wait_in

      read_burst(r[2], 0, `SPI_REG_COUNT);    // full final compare

      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
